//--- all.f
wdb_pkg.sv
parity_gen.sv
line_ram.sv
write_data_control.sv
buffer_config.sv
wdb_top.sv
tb_wdb.sv

//--- tb_wdb.sv
/* directed testbench for the write-data staging buffer
   reference line memory model, per-cycle output checks */
`timescale 1ns/1ps
`default_nettype none

module tb_wdb;

  import wdb_pkg::*;

  logic                       clock;
  logic                       rstn;
  logic                       cfg_write;
  cfg_reg_e                   cfg_addr;
  logic [cfg_data_width-1:0]  cfg_wdata;
  logic [cfg_data_width-1:0]  cfg_rdata;
  logic                       command_write_valid;
  logic [tag_width-1:0]       command_tag;
  logic [half_line_bits-1:0]  write_data_0;
  logic [half_line_bits-1:0]  write_data_1;
  logic                       read_valid;
  logic [tag_width-1:0]       read_tag;
  logic                       read_tag_parity;
  logic [read_addr_width-1:0] read_address;
  logic [half_line_bits-1:0]  read_data;
  logic [parity_bits-1:0]     read_parity;
  logic                       data_write_error;

  // reference memory, one array per half
  logic [half_line_bits-1:0] model0 [2**tag_width];
  logic [half_line_bits-1:0] model1 [2**tag_width];
  // expected output slots, index = edges since the request was driven
  logic [half_line_bits-1:0] exp_data [1:read_latency];
  logic                      exp_err  [1:read_latency+1];
  logic [half_line_bits-1:0] pend_data;
  logic                      pend_err;
  logic                      tb_enable;
  logic                      tb_err_enable;
  int                        exp_count;
  int                        errors;
  int                        checks;
  integer                    seed;

  wdb_top uut (.*);

  always #2 clock = ~clock;

  ////////////////////
  // reference rules
  ////////////////////

  // bit that makes the word plus itself hold an odd number of ones
  function automatic logic odd_parity(input logic [63:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 64; i++) begin
      ones += v[i];
    end
    return (ones % 2 == 0);
  endfunction

  function automatic logic [parity_bits-1:0] dword_parity(input logic [half_line_bits-1:0] d);
    logic [parity_bits-1:0] p;
    for (int i = 0; i < parity_bits; i++) begin
      p[i] = odd_parity(d[i*dword_bits +: dword_bits]);
    end
    return p;
  endfunction

  function automatic logic [half_line_bits-1:0] random_half();
    logic [half_line_bits-1:0] d;
    for (int i = 0; i < half_line_bits / 32; i++) begin
      d[i*32 +: 32] = $random(seed);
    end
    return d;
  endfunction

  ////////////////////
  // cycle helpers
  ////////////////////

  // one edge, shift expectations, check the outputs due now
  task automatic tick();
    @(posedge clock);
    #0.5;
    for (int i = read_latency; i > 1; i--) exp_data[i] = exp_data[i-1];
    for (int i = read_latency + 1; i > 1; i--) exp_err[i] = exp_err[i-1];
    exp_data[1] = pend_data;
    exp_err[1]  = pend_err;
    pend_data   = '1;
    pend_err    = 1'b0;
    checks++;
    if (read_data !== exp_data[read_latency]) begin
      errors++;
      $display("** Error at %0t: read_data expected %h got %h",
               $time, exp_data[read_latency], read_data);
    end
    if (read_parity !== dword_parity(exp_data[read_latency])) begin
      errors++;
      $display("** Error at %0t: read_parity expected %h got %h",
               $time, dword_parity(exp_data[read_latency]), read_parity);
    end
    if (data_write_error !== exp_err[read_latency+1]) begin
      errors++;
      $display("** Error at %0t: data_write_error expected %b got %b",
               $time, exp_err[read_latency+1], data_write_error);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic cfg_write_reg(input cfg_reg_e addr, input logic [cfg_data_width-1:0] data);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_write = 1'b0;
  endtask

  // combinational read, sampled mid-cycle
  task automatic cfg_expect(input cfg_reg_e addr, input logic [cfg_data_width-1:0] value);
    cfg_addr = addr;
    #0.5;
    checks++;
    if (cfg_rdata !== value) begin
      errors++;
      $display("** Error at %0t: cfg_rdata[%s] expected %h got %h",
               $time, addr.name(), value, cfg_rdata);
    end
  endtask

  // ctrl write plus the extra enable register stage
  task automatic set_ctrl(input logic en, input logic err_en);
    cfg_write_reg(cfg_ctrl, {14'd0, err_en, en});
    tb_enable     = en;
    tb_err_enable = err_en;
    idle(1);
  endtask

  task automatic write_line(input logic [tag_width-1:0] tag);
    command_write_valid = 1'b1;
    command_tag         = tag;
    write_data_0        = random_half();
    write_data_1        = random_half();
    // disabled writes must not reach the memories
    if (tb_enable) begin
      model0[tag] = write_data_0;
      model1[tag] = write_data_1;
    end
    tick();
    command_write_valid = 1'b0;
  endtask

  task automatic read_request(input logic [tag_width-1:0] tag,
                              input logic [read_addr_width-1:0] addr, input logic bad_par);
    read_valid      = 1'b1;
    read_tag        = tag;
    read_address    = addr;
    read_tag_parity = odd_parity({56'd0, tag}) ^ bad_par;
    if (tb_enable) begin
      pend_data = (addr == 0) ? model0[tag] : model1[tag];
      pend_err  = bad_par & tb_err_enable;
      if (bad_par) exp_count++;
    end
    tick();
    read_valid = 1'b0;
  endtask

  // status flag poll, bounded
  task automatic wait_status_flag();
    int n;
    n = 0;
    cfg_addr = cfg_status;
    #0.5;
    while (cfg_rdata[status_tag_err_bit] !== 1'b1 && n < 8) begin
      tick();
      n++;
    end
    checks++;
    if (cfg_rdata[status_tag_err_bit] !== 1'b1) begin
      errors++;
      $display("tag error flag never set within 8 cycles at %0t", $time);
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic reset_defaults();
    idle(4);
    cfg_expect(cfg_ctrl, 16'h0);
    cfg_expect(cfg_status, 16'h0);
    cfg_expect(cfg_err_count, 16'h0);
  endtask

  task automatic write_then_read();
    set_ctrl(1'b1, 1'b0);
    for (int i = 0; i < 6; i++) write_line(8'(i * 37 + 3));
    idle(1);
    for (int i = 0; i < 6; i++) begin
      read_request(8'(i * 37 + 3), '0, 1'b0);
      idle(3);
      read_request(8'(i * 37 + 3), 6'({$random(seed)} % 63 + 1), 1'b0);
      idle(3);
    end
  endtask

  task automatic back_to_back_reads();
    for (int i = 0; i < 6; i++) read_request(8'(i * 37 + 3), (i % 2) ? 6'h2a : 6'h00, 1'b0);
    idle(4);
    for (int i = 5; i > 2; i--) read_request(8'(i * 37 + 3), (i % 2) ? 6'h00 : 6'h3f, 1'b0);
    idle(4);
  endtask

  task automatic tag_error_reported();
    set_ctrl(1'b1, 1'b1);
    read_request(8'd3, '0, 1'b1);
    idle(5);
    wait_status_flag();
    cfg_expect(cfg_err_count, 16'(exp_count));
    cfg_write_reg(cfg_status, 16'h1);
    cfg_expect(cfg_status, 16'h0);
    cfg_write_reg(cfg_err_count, 16'h0);
    exp_count = 0;
    cfg_expect(cfg_err_count, 16'h0);
    // good parity, nothing raised
    read_request(8'd40, 6'h01, 1'b0);
    idle(5);
    cfg_expect(cfg_status, 16'h0);
    cfg_expect(cfg_err_count, 16'h0);
  endtask

  task automatic tag_error_masked();
    set_ctrl(1'b1, 1'b0);
    read_request(8'd77, 6'h04, 1'b1);
    idle(5);
    wait_status_flag();
    cfg_expect(cfg_err_count, 16'(exp_count));
    cfg_write_reg(cfg_status, 16'h1);
    cfg_write_reg(cfg_err_count, 16'h0);
    exp_count = 0;
  endtask

  task automatic disabled_path();
    set_ctrl(1'b0, 1'b1);
    write_line(8'd114);
    idle(1);
    read_request(8'd114, '0, 1'b1);
    idle(5);
    cfg_expect(cfg_status, 16'h0);
    cfg_expect(cfg_err_count, 16'h0);
    // old contents still there once enabled again
    set_ctrl(1'b1, 1'b1);
    read_request(8'd114, '0, 1'b0);
    read_request(8'd114, 6'h05, 1'b0);
    idle(5);
  endtask

  initial begin
    seed                = 32'h2bc0_f602;
    clock               = 1'b0;
    rstn                = 1'b0;
    cfg_write           = 1'b0;
    cfg_addr            = cfg_ctrl;
    cfg_wdata           = '0;
    command_write_valid = 1'b0;
    command_tag         = '0;
    write_data_0        = '0;
    write_data_1        = '0;
    read_valid          = 1'b0;
    read_tag            = '0;
    read_tag_parity     = 1'b0;
    read_address        = '0;
    pend_data           = '1;
    pend_err            = 1'b0;
    tb_enable           = 1'b0;
    tb_err_enable       = 1'b0;
    exp_count           = 0;
    errors              = 0;
    checks              = 0;
    for (int i = 1; i <= read_latency; i++) exp_data[i] = '1;
    for (int i = 1; i <= read_latency + 1; i++) exp_err[i] = 1'b0;
    repeat (5) @(posedge clock);
    #0.5;
    rstn = 1'b1;

    reset_defaults();
    write_then_read();
    back_to_back_reads();
    tag_error_reported();
    tag_error_masked();
    disabled_path();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- wdb_top.sv
/* write-data staging buffer top level
   config register block feeding the data control path */
`timescale 1ns/1ps
`default_nettype none

module wdb_top (
  input  logic                                 clock,
  input  logic                                 rstn,
  // config side
  input  logic                                 cfg_write,
  input  wdb_pkg::cfg_reg_e                    cfg_addr,
  input  logic [wdb_pkg::cfg_data_width-1:0]   cfg_wdata,
  output logic [wdb_pkg::cfg_data_width-1:0]   cfg_rdata,
  // write side
  input  logic                                 command_write_valid,
  input  logic [wdb_pkg::tag_width-1:0]        command_tag,
  input  logic [wdb_pkg::half_line_bits-1:0]   write_data_0,
  input  logic [wdb_pkg::half_line_bits-1:0]   write_data_1,
  // buffer read side
  input  logic                                 read_valid,
  input  logic [wdb_pkg::tag_width-1:0]        read_tag,
  input  logic                                 read_tag_parity,
  input  logic [wdb_pkg::read_addr_width-1:0]  read_address,
  output logic [wdb_pkg::half_line_bits-1:0]   read_data,
  output logic [wdb_pkg::parity_bits-1:0]      read_parity,
  output logic                                 data_write_error
);

  // config to data path
  logic enable;
  logic error_enable;
  // data path back to status
  logic tag_error;

  buffer_config u_config (
    .clock        (clock),
    .rstn         (rstn),
    .cfg_write    (cfg_write),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .tag_error    (tag_error),
    .cfg_rdata    (cfg_rdata),
    .enable       (enable),
    .error_enable (error_enable)
  );

  write_data_control u_control (
    .clock               (clock),
    .rstn                (rstn),
    .enable              (enable),
    .error_enable        (error_enable),
    .command_write_valid (command_write_valid),
    .command_tag         (command_tag),
    .write_data_0        (write_data_0),
    .write_data_1        (write_data_1),
    .read_valid          (read_valid),
    .read_tag            (read_tag),
    .read_tag_parity     (read_tag_parity),
    .read_address        (read_address),
    .read_data           (read_data),
    .read_parity         (read_parity),
    .tag_error           (tag_error),
    .data_write_error    (data_write_error)
  );

endmodule

`default_nettype wire

//--- buffer_config.sv
/* configuration and status registers for the write-data buffer
   enables, sticky tag error flag and saturating error count */
`timescale 1ns/1ps
`default_nettype none

module buffer_config (
  input  logic                               clock,
  input  logic                               rstn,
  input  logic                               cfg_write,
  input  wdb_pkg::cfg_reg_e                  cfg_addr,
  input  logic [wdb_pkg::cfg_data_width-1:0] cfg_wdata,
  input  logic                               tag_error,
  output logic [wdb_pkg::cfg_data_width-1:0] cfg_rdata,
  output logic                               enable,
  output logic                               error_enable
);

  import wdb_pkg::*;

  logic                       tag_err_flag;
  logic [err_count_width-1:0] err_count;
  logic                       status_clear;
  logic                       count_clear;

  assign status_clear = cfg_write && (cfg_addr == cfg_status) &&
                        cfg_wdata[status_tag_err_bit];
  assign count_clear  = cfg_write && (cfg_addr == cfg_err_count);

  ////////////////////
  // register updates
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enable       <= 1'b0;
      error_enable <= 1'b0;
    end else if (cfg_write && (cfg_addr == cfg_ctrl)) begin
      enable       <= cfg_wdata[ctrl_enable_bit];
      error_enable <= cfg_wdata[ctrl_err_enable_bit];
    end
  end

  // new error beats a clear in the same cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_err_flag <= 1'b0;
    end else if (tag_error) begin
      tag_err_flag <= 1'b1;
    end else if (status_clear) begin
      tag_err_flag <= 1'b0;
    end
  end

  // clear restarts at 1 if an error lands with it
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_count <= '0;
    end else if (count_clear) begin
      err_count <= {{(err_count_width-1){1'b0}}, tag_error};
    end else if (tag_error && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

  ////////////////////
  // read mux
  ////////////////////

  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      cfg_ctrl: begin
        cfg_rdata[ctrl_enable_bit]     = enable;
        cfg_rdata[ctrl_err_enable_bit] = error_enable;
      end
      cfg_status:    cfg_rdata[status_tag_err_bit] = tag_err_flag;
      cfg_err_count: cfg_rdata = err_count;
      default:       cfg_rdata = '0;
    endcase
  end

  // count only drops right after a count register write
  assert property (@(posedge clock) disable iff (!rstn)
    (err_count < $past(err_count)) |-> $past(count_clear))
    else $error("error count decreased without a clear");

endmodule

`default_nettype wire

//--- write_data_control.sv
/* write capture and fixed-latency buffer read pipeline
   with per-dword odd parity and tag parity checking */
`timescale 1ns/1ps
`default_nettype none

module write_data_control (
  input  logic                                 clock,
  input  logic                                 rstn,
  input  logic                                 enable,
  input  logic                                 error_enable,
  input  logic                                 command_write_valid,
  input  logic [wdb_pkg::tag_width-1:0]        command_tag,
  input  logic [wdb_pkg::half_line_bits-1:0]   write_data_0,
  input  logic [wdb_pkg::half_line_bits-1:0]   write_data_1,
  input  logic                                 read_valid,
  input  logic [wdb_pkg::tag_width-1:0]        read_tag,
  input  logic                                 read_tag_parity,
  input  logic [wdb_pkg::read_addr_width-1:0]  read_address,
  output logic [wdb_pkg::half_line_bits-1:0]   read_data,
  output logic [wdb_pkg::parity_bits-1:0]      read_parity,
  output logic                                 tag_error,
  output logic                                 data_write_error
);

  import wdb_pkg::*;

  logic                      enable_q;

  // latched write
  logic                      wr_valid_q;
  logic [tag_width-1:0]      wr_tag_q;
  logic [half_line_bits-1:0] wr_data0_q;
  logic [half_line_bits-1:0] wr_data1_q;

  // registered read request
  logic                      rd_valid_q;
  logic                      rd_half_q;
  logic [tag_width-1:0]      rd_tag_q;
  logic                      rd_tag_par_q;

  logic [half_line_bits-1:0] ram0_data;
  logic [half_line_bits-1:0] ram1_data;
  logic [half_line_bits-1:0] sel_data;
  logic [parity_bits-1:0]    sel_parity;
  logic                      tag_calc_parity;
  logic                      err_detect;

  // enable seen one edge after the config block
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= enable;
    end
  end

  ////////////////////
  // write capture
  ////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= command_write_valid & enable_q;
    end
  end

  // payload, no reset
  always_ff @(posedge clock) begin
    if (command_write_valid && enable_q) begin
      wr_tag_q   <= command_tag;
      wr_data0_q <= write_data_0;
      wr_data1_q <= write_data_1;
    end
  end

  line_ram u_ram_half0 (
    .clock        (clock),
    .write_enable (wr_valid_q),
    .write_addr   (wr_tag_q),
    .write_data   (wr_data0_q),
    .read_addr    (read_tag),
    .read_data    (ram0_data)
  );

  line_ram u_ram_half1 (
    .clock        (clock),
    .write_enable (wr_valid_q),
    .write_addr   (wr_tag_q),
    .write_data   (wr_data1_q),
    .read_addr    (read_tag),
    .read_data    (ram1_data)
  );

  ////////////////////
  // read pipeline
  ////////////////////

  // stage 1, request regs alongside the memory read
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= read_valid & enable_q;
    end
  end

  always_ff @(posedge clock) begin
    rd_half_q    <= |read_address;
    rd_tag_q     <= read_tag;
    rd_tag_par_q <= read_tag_parity;
  end

  // stage 2, half select, all ones when idle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      sel_data <= '1;
    end else if (!rd_valid_q) begin
      sel_data <= '1;
    end else if (rd_half_q) begin
      sel_data <= ram1_data;
    end else begin
      sel_data <= ram0_data;
    end
  end

  parity_gen #(
    .slice_bits (dword_bits),
    .data_bits  (half_line_bits)
  ) u_data_parity (
    .data   (sel_data),
    .parity (sel_parity)
  );

  // stage 3, output regs
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_data   <= '1;
      read_parity <= '1;
    end else begin
      read_data   <= sel_data;
      read_parity <= sel_parity;
    end
  end

  ////////////////////
  // tag parity check
  ////////////////////

  parity_gen #(
    .slice_bits (tag_width),
    .data_bits  (tag_width)
  ) u_tag_parity (
    .data   (rd_tag_q),
    .parity (tag_calc_parity)
  );

  // tag_error at k+2, detect at k+3, output at k+4
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_error        <= 1'b0;
      err_detect       <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_error        <= rd_valid_q & (rd_tag_par_q != tag_calc_parity);
      err_detect       <= tag_error;
      data_write_error <= err_detect & error_enable;
    end
  end

  // host error line only follows an enabled error path
  assert property (@(posedge clock) disable iff (!rstn)
    $rose(data_write_error) |-> $past(error_enable))
    else $error("data_write_error rose with error_enable low");

  // error pulse traces back to a request registered one edge before
  assert property (@(posedge clock) disable iff (!rstn)
    tag_error |-> $past(rd_valid_q))
    else $error("tag_error without a registered request");

endmodule

`default_nettype wire

//--- line_ram.sv
/* half cache line memory indexed by command tag
   synchronous write, registered read */
`timescale 1ns/1ps
`default_nettype none

module line_ram (
  input  logic                               clock,
  input  logic                               write_enable,
  input  logic [wdb_pkg::tag_width-1:0]      write_addr,
  input  logic [wdb_pkg::half_line_bits-1:0] write_data,
  input  logic [wdb_pkg::tag_width-1:0]      read_addr,
  output logic [wdb_pkg::half_line_bits-1:0] read_data
);

  import wdb_pkg::*;

  // one entry per tag
  logic [half_line_bits-1:0] mem [2**tag_width];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clock) begin
    if (write_enable) begin
      mem[write_addr] <= write_data;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // same-edge read of a written entry returns old contents
  always_ff @(posedge clock) begin
    read_data <= mem[read_addr];
  end

endmodule

`default_nettype wire

//--- parity_gen.sv
/* odd parity generator, one bit per slice of slice_bits */
`timescale 1ns/1ps
`default_nettype none

module parity_gen #(
  parameter int slice_bits = 64,
  parameter int data_bits  = 512
) (
  input  logic [data_bits-1:0]              data,
  output logic [data_bits/slice_bits-1:0]   parity
);

  ////////////////////
  // per-slice parity
  ////////////////////

  always_comb begin
    for (int i = 0; i < data_bits / slice_bits; i++) begin
      // slice plus its parity bit holds an odd number of ones
      parity[i] = ~(^data[i*slice_bits +: slice_bits]);
    end
  end

  // slices must tile the data exactly
  initial begin
    if (data_bits % slice_bits != 0) begin
      $error("data_bits is not a multiple of slice_bits");
    end
  end

endmodule

`default_nettype wire

//--- wdb_pkg.sv
/* write-data staging buffer definitions
   widths, fixed read latency and configuration register map */
`default_nettype none

package wdb_pkg;

  ////////////////////
  // line geometry
  ////////////////////

  // command tag, also the line memory index
  localparam int tag_width       = 8;
  // one half cache line per memory entry
  localparam int half_line_bits  = 512;
  // one parity bit per double word
  localparam int dword_bits      = 64;
  localparam int parity_bits     = half_line_bits / dword_bits;
  // buffer read address, zero selects half 0
  localparam int read_addr_width = 6;

  // edges from request sample to data on the outputs
  localparam int read_latency    = 3;

  ////////////////////
  // config registers
  ////////////////////

  localparam int cfg_data_width      = 16;
  localparam int err_count_width     = 16;
  // ctrl register bits
  localparam int ctrl_enable_bit     = 0;
  localparam int ctrl_err_enable_bit = 1;
  // status register bits, write 1 to clear
  localparam int status_tag_err_bit  = 0;

  typedef enum logic [1:0] {
    cfg_ctrl      = 2'd0,
    cfg_status    = 2'd1,
    cfg_err_count = 2'd2
  } cfg_reg_e;

endpackage

`default_nettype wire
